// File: build.f
design/spm_split_pkg.sv
design/way_sram.sv
design/port_router.sv
design/ext_port_arbiter.sv
design/dspm_ctrl.sv
design/dcache_spm_split.sv
tests/tb_dcache_spm_split.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_dcache_spm_split
LOG=sim.log

if ! verilator --binary -Wno-fatal --top-module "$TOP" -f build.f -o "$TOP"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Run failed, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Run passed"
exit 0

// File: tests/tb_dcache_spm_split.sv
`timescale 1ns/1ns

module ext_mem_responder #(
  parameter logic [15:0] PATTERN = 16'h0000
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  spm_split_pkg::mem_req_t req_i,
  output spm_split_pkg::mem_rsp_t rsp_o
);

  logic [31:0] store [int];
  logic [31:0] word;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  int          key;

  // Grants at once, answers a read one cycle later
  assign rsp_o = '{data_gnt: req_i.data_req, data_rvalid: rvalid_q, rdata: rdata_q};

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      key  = int'(req_i.addr[15:2]);
      word = {2{{req_i.addr[15:2], 2'b00} ^ PATTERN}};
      if (store.exists(key)) word = store[key];
      if (req_i.data_req && req_i.data_we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) word[b*8 +: 8] = req_i.wdata[b*8 +: 8];
        end
        store[key] = word;
      end
      rvalid_q <= req_i.data_req && !req_i.data_we;
      rdata_q  <= word;
    end
  end

endmodule

module tb_dcache_spm_split;

  localparam int          CLK_PERIOD    = 100;
  localparam int          N_DSPM        = 16;
  localparam int          N_EXT         = 8;
  localparam int          NUM_TXNS      = 3 * N_DSPM + 7 + 5 * N_EXT + 3 + 2 + 2;
  localparam logic [15:0] ISPM_PATTERN  = 16'h5a5a;
  localparam logic [15:0] CACHE_PATTERN = 16'hc3a5;

  logic                          clk_i;
  logic                          rst_n_i;
  logic                          stall_i;
  logic [3:0]                    spm_ways_i;
  spm_split_pkg::mem_req_t [1:0] req_ports_i;
  spm_split_pkg::mem_rsp_t [1:0] req_ports_o;
  spm_split_pkg::mem_req_t       ispm_req_o;
  spm_split_pkg::mem_req_t       cache_req_o;
  spm_split_pkg::mem_rsp_t       ispm_rsp_i;
  spm_split_pkg::mem_rsp_t       cache_rsp_i;

  integer      seed;
  int unsigned cycle = 0;
  int unsigned gnt_count [2] = '{0, 0};
  int unsigned gnt_cycle [2];
  int unsigned rvalid_cycle [2];
  logic [1:0]  pending;
  logic [31:0] exp_data [2];
  logic [31:0] dspm_shadow [int];
  logic [31:0] ispm_shadow [int];
  logic [31:0] cache_shadow [int];

  dcache_spm_split DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .spm_ways_i  (spm_ways_i),
    .req_ports_i (req_ports_i),
    .req_ports_o (req_ports_o),
    .ispm_req_o  (ispm_req_o),
    .ispm_rsp_i  (ispm_rsp_i),
    .cache_req_o (cache_req_o),
    .cache_rsp_i (cache_rsp_i)
  );

  ext_mem_responder #(.PATTERN(ISPM_PATTERN)) u_ispm_mem (
    clk_i, rst_n_i, ispm_req_o, ispm_rsp_i
  );
  ext_mem_responder #(.PATTERN(CACHE_PATTERN)) u_cache_mem (
    clk_i, rst_n_i, cache_req_o, cache_rsp_i
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic in_dspm(input logic [15:0] addr);
    return addr >= spm_split_pkg::DSPM_BASE &&
           addr < spm_split_pkg::DSPM_BASE + spm_split_pkg::DSPM_LENGTH;
  endfunction

  function automatic logic in_ispm(input logic [15:0] addr);
    return addr >= spm_split_pkg::ISPM_BASE &&
           addr < spm_split_pkg::ISPM_BASE + spm_split_pkg::ISPM_LENGTH;
  endfunction

  function automatic logic [31:0] expected_read(input logic [15:0] addr);
    int          key;
    logic [31:0] fill;
    key  = int'(addr[15:2]);
    fill = {2{addr & 16'hfffc}};
    if (in_dspm(addr)) begin
      // Ways left to the cache read as zero
      if (!spm_ways_i[addr[11:10]]) return '0;
      return dspm_shadow.exists(key) ? dspm_shadow[key] : '0;
    end
    if (in_ispm(addr)) begin
      return ispm_shadow.exists(key) ? ispm_shadow[key] : fill ^ {2{ISPM_PATTERN}};
    end
    return cache_shadow.exists(key) ? cache_shadow[key] : fill ^ {2{CACHE_PATTERN}};
  endfunction

  function automatic void update_shadow(input spm_split_pkg::mem_req_t req);
    logic [31:0] word;
    int          key;
    key  = int'(req.addr[15:2]);
    word = expected_read(req.addr);
    for (int b = 0; b < 4; b++) begin
      if (req.be[b]) word[b*8 +: 8] = req.wdata[b*8 +: 8];
    end
    if (in_dspm(req.addr)) begin
      if (spm_ways_i[req.addr[11:10]]) dspm_shadow[key] = word;
    end else if (in_ispm(req.addr)) begin
      ispm_shadow[key] = word;
    end else begin
      cache_shadow[key] = word;
    end
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_quiet(input string what);
    for (int p = 0; p < 2; p++) begin
      check(req_ports_o[p].data_gnt, 0, what);
      check(req_ports_o[p].data_rvalid, 0, what);
    end
    check(ispm_req_o.data_req, 0, what);
    check(cache_req_o.data_req, 0, what);
  endtask

  // Hold a request until granted, then wait for read data
  task automatic access(input int p, input logic we, input logic [15:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be);
    int unsigned start;
    start = gnt_count[p];
    @(negedge clk_i);
    req_ports_i[p] = '{data_req: 1'b1, data_we: we, addr: addr, wdata: wdata, be: be};
    while (gnt_count[p] == start) @(negedge clk_i);
    req_ports_i[p].data_req = 1'b0;
    while (!we && pending[p]) @(negedge clk_i);
  endtask

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------
  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (!rst_n_i) begin
      check_quiet("strobe high during reset");
    end else begin
      if (stall_i) begin
        check(req_ports_o[0].data_gnt || req_ports_o[1].data_gnt, 0, "grant while stalled");
        check(ispm_req_o.data_req || cache_req_o.data_req, 0, "external request while stalled");
      end
      if (ispm_req_o.data_req) begin
        check(in_ispm(ispm_req_o.addr), 1, "wrong address at ISPM port");
        check(ispm_req_o == req_ports_i[0] || ispm_req_o == req_ports_i[1], 1,
              "ISPM request altered");
      end
      if (cache_req_o.data_req) begin
        check(!in_dspm(cache_req_o.addr) && !in_ispm(cache_req_o.addr), 1,
              "SPM address at cache port");
        check(cache_req_o == req_ports_i[0] || cache_req_o == req_ports_i[1], 1,
              "cache request altered");
      end
      for (int p = 0; p < 2; p++) begin
        if (req_ports_o[p].data_rvalid) begin
          check(pending[p], 1, "rvalid without a pending read");
          check(cycle, gnt_cycle[p] + 1, "rvalid not one cycle after grant");
          check(req_ports_o[p].rdata, exp_data[p], "read data");
          pending[p]      = 1'b0;
          rvalid_cycle[p] = cycle;
        end
        if (req_ports_o[p].data_gnt) begin
          gnt_cycle[p] = cycle;
          gnt_count[p] = gnt_count[p] + 1;
          if (req_ports_i[p].data_we) begin
            update_shadow(req_ports_i[p]);
          end else begin
            pending[p]  = 1'b1;
            exp_data[p] = expected_read(req_ports_i[p].addr);
          end
        end
      end
    end
  end

  initial begin
    #((NUM_TXNS * 20 + 100) * CLK_PERIOD);
    $display("Timeout: the tests did not complete in the expected time");
    $display("Simulation FAILED");
    $fatal(1);
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [15:0] addr;
    logic [15:0] dspm_addr [N_DSPM];
    seed        = 32'ha3f0_e3bd;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    stall_i     = 1'b0;
    spm_ways_i  = 4'hf;
    req_ports_i = '0;
    pending     = '0;
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_quiet("strobe high after reset");

    // Full word first, then a partial merge from the other port
    for (int i = 0; i < N_DSPM; i++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      addr = {4'h8, rnd[11:2], 2'b00};
      dspm_addr[i] = addr;
      access(i % 2, 1'b1, addr, rnd2, 4'hf);
      rnd2 = $random(seed);
      access((i + 1) % 2, 1'b1, addr, rnd2, rnd[15:12]);
    end
    for (int i = 0; i < N_DSPM; i++) begin
      access(i % 2, 1'b0, dspm_addr[i], '0, '0);
    end

    // Way 2 covers 0x8800 to 0x8bff
    access(0, 1'b1, 16'h8840, 32'h1234_5678, 4'hf);
    spm_ways_i = 4'b1011;
    access(0, 1'b0, 16'h8840, '0, '0);
    access(1, 1'b1, 16'h8840, 32'hdead_beef, 4'hf);
    access(1, 0, 16'h8840, '0, '0);
    // Way 3 stays with the SPM
    access(0, 1'b1, 16'h8c40, 32'h5566_7788, 4'hf);
    access(0, 1'b0, 16'h8c40, '0, '0);
    spm_ways_i = 4'hf;
    access(1, 1'b0, 16'h8840, '0, '0);

    for (int i = 0; i < N_EXT; i++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      addr = {4'ha, rnd[11:2], 2'b00};
      access(i % 2, 1'b1, addr, rnd2, rnd[15:12]);
      access((i + 1) % 2, 1'b0, addr, '0, '0);
      access(i % 2, 1'b0, {4'ha, rnd[27:18], 2'b00}, '0, '0);
      addr = {1'b0, rnd2[14:2], 2'b00};
      access(i % 2, 1'b1, addr, rnd, 4'hf);
      access((i + 1) % 2, 1'b0, addr, '0, '0);
    end
    access(0, 1'b0, 16'h9000, '0, '0);
    access(1, 1'b0, 16'hb000, '0, '0);
    access(0, 1'b0, 16'hfffc, '0, '0);

    // Port 1 reads the ISPM in the same cycle as port 0 and waits for its data
    fork
      access(0, 1'b0, 16'ha100, '0, '0);
      access(1, 1'b0, 16'ha204, '0, '0);
    join
    check(gnt_cycle[1] > rvalid_cycle[0], 1, "port 1 granted before port 0 read ended");

    stall_i = 1'b1;
    fork
      access(0, 1'b0, 16'ha300, '0, '0);
      access(1, 1'b1, 16'h1000, 32'h0bad_cafe, 4'hf);
      begin
        repeat (4) @(negedge clk_i);
        stall_i = 1'b0;
      end
    join

    if (pending == 2'b00) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("A read was still waiting for its data at the end of the run");
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

// File: design/dcache_spm_split.sv
`timescale 1ns/1ns

module dcache_spm_split (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  stall_i,
  input  logic [spm_split_pkg::NUM_WAYS-1:0]                    spm_ways_i,
  input  spm_split_pkg::mem_req_t [spm_split_pkg::NUM_PORTS-1:0] req_ports_i,
  output spm_split_pkg::mem_rsp_t [spm_split_pkg::NUM_PORTS-1:0] req_ports_o,
  output spm_split_pkg::mem_req_t                               ispm_req_o,
  input  spm_split_pkg::mem_rsp_t                               ispm_rsp_i,
  output spm_split_pkg::mem_req_t                               cache_req_o,
  input  spm_split_pkg::mem_rsp_t                               cache_rsp_i
);

  spm_split_pkg::mem_req_t [spm_split_pkg::NUM_PORTS-1:0] dspm_req, ispm_req, cache_req;
  spm_split_pkg::mem_rsp_t [spm_split_pkg::NUM_PORTS-1:0] dspm_rsp, ispm_rsp, cache_rsp;

  logic [spm_split_pkg::NUM_WAYS-1:0]                               ram_req;
  logic                                                             ram_we;
  logic [spm_split_pkg::WAY_IDX_WIDTH-1:0]                          ram_addr;
  logic [spm_split_pkg::DATA_WIDTH-1:0]                             ram_wdata;
  logic [spm_split_pkg::BE_WIDTH-1:0]                               ram_be;
  logic [spm_split_pkg::NUM_WAYS-1:0][spm_split_pkg::DATA_WIDTH-1:0] ram_rdata;

  // --------------------------------------------------
  // One router per request port
  // --------------------------------------------------
  for (genvar i = 0; i < spm_split_pkg::NUM_PORTS; i++) begin : g_router
    port_router u_router (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .stall_i     (stall_i),
      .req_i       (req_ports_i[i]),
      .rsp_o       (req_ports_o[i]),
      .dspm_req_o  (dspm_req[i]),
      .ispm_req_o  (ispm_req[i]),
      .cache_req_o (cache_req[i]),
      .dspm_rsp_i  (dspm_rsp[i]),
      .ispm_rsp_i  (ispm_rsp[i]),
      .cache_rsp_i (cache_rsp[i])
    );
  end

  // Both external ports share the same arbitration scheme
  ext_port_arbiter u_ispm_arb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (ispm_req),
    .rsp_o     (ispm_rsp),
    .ext_req_o (ispm_req_o),
    .ext_rsp_i (ispm_rsp_i)
  );

  ext_port_arbiter u_cache_arb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (cache_req),
    .rsp_o     (cache_rsp),
    .ext_req_o (cache_req_o),
    .ext_rsp_i (cache_rsp_i)
  );

  // --------------------------------------------------
  // Data SPM
  // --------------------------------------------------
  dspm_ctrl u_dspm_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .spm_ways_i  (spm_ways_i),
    .req_i       (dspm_req),
    .rsp_o       (dspm_rsp),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be),
    .ram_rdata_i (ram_rdata)
  );

  for (genvar w = 0; w < spm_split_pkg::NUM_WAYS; w++) begin : g_way
    way_sram u_way (
      .clk_i   (clk_i),
      .req_i   (ram_req[w]),
      .we_i    (ram_we),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .be_i    (ram_be),
      .rdata_o (ram_rdata[w])
    );
  end

endmodule

// File: design/dspm_ctrl.sv
`timescale 1ns/1ns

module dspm_ctrl (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [spm_split_pkg::NUM_WAYS-1:0]                    spm_ways_i,
  input  spm_split_pkg::mem_req_t [spm_split_pkg::NUM_PORTS-1:0] req_i,
  output spm_split_pkg::mem_rsp_t [spm_split_pkg::NUM_PORTS-1:0] rsp_o,
  output logic [spm_split_pkg::NUM_WAYS-1:0]                    ram_req_o,
  output logic                                                  ram_we_o,
  output logic [spm_split_pkg::WAY_IDX_WIDTH-1:0]               ram_addr_o,
  output logic [spm_split_pkg::DATA_WIDTH-1:0]                  ram_wdata_o,
  output logic [spm_split_pkg::BE_WIDTH-1:0]                    ram_be_o,
  input  logic [spm_split_pkg::NUM_WAYS-1:0][spm_split_pkg::DATA_WIDTH-1:0] ram_rdata_i
);

  logic [spm_split_pkg::PORT_SEL_WIDTH-1:0] sel_port, port_q;
  logic [spm_split_pkg::WAY_SEL_WIDTH-1:0]  sel_way, way_q;
  logic                                     any_req;
  logic                                     owned_q;
  logic                                     rvalid_q;
  spm_split_pkg::mem_req_t                  sel_req;

  // --------------------------------------------------
  // Port arbitration, fixed priority
  // --------------------------------------------------
  always_comb begin
    sel_port = '0;
    any_req  = 1'b0;
    for (int i = spm_split_pkg::NUM_PORTS - 1; i >= 0; i--) begin
      if (req_i[i].data_req) begin
        sel_port = i[spm_split_pkg::PORT_SEL_WIDTH-1:0];
        any_req  = 1'b1;
      end
    end
  end

  assign sel_req = req_i[sel_port];
  // Way select sits right above the word index
  assign sel_way = sel_req.addr[spm_split_pkg::BYTE_OFF_WIDTH + spm_split_pkg::WAY_IDX_WIDTH +:
                                spm_split_pkg::WAY_SEL_WIDTH];

  // Ways still owned by the cache never see a request
  always_comb begin
    ram_req_o          = '0;
    ram_req_o[sel_way] = any_req && spm_ways_i[sel_way];
  end

  assign ram_we_o    = sel_req.data_we;
  assign ram_addr_o  = sel_req.addr[spm_split_pkg::BYTE_OFF_WIDTH +: spm_split_pkg::WAY_IDX_WIDTH];
  assign ram_wdata_o = sel_req.wdata;
  assign ram_be_o    = sel_req.be;

  always_comb begin
    for (int i = 0; i < spm_split_pkg::NUM_PORTS; i++) begin
      rsp_o[i].data_gnt    = any_req && (sel_port == i);
      rsp_o[i].data_rvalid = rvalid_q && (port_q == i);
      rsp_o[i].rdata       = owned_q ? ram_rdata_i[way_q] : '0;
    end
  end

  // Remember who gets the read data next cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      port_q   <= '0;
      way_q    <= '0;
      owned_q  <= 1'b0;
    end else begin
      rvalid_q <= any_req && !sel_req.data_we;
      if (any_req) begin
        port_q  <= sel_port;
        way_q   <= sel_way;
        owned_q <= spm_ways_i[sel_way];
      end
    end
  end

endmodule

// File: design/ext_port_arbiter.sv
`timescale 1ns/1ns

module ext_port_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  spm_split_pkg::mem_req_t [spm_split_pkg::NUM_PORTS-1:0] req_i,
  output spm_split_pkg::mem_rsp_t [spm_split_pkg::NUM_PORTS-1:0] rsp_o,
  output spm_split_pkg::mem_req_t                               ext_req_o,
  input  spm_split_pkg::mem_rsp_t                               ext_rsp_i
);

  logic [spm_split_pkg::PORT_SEL_WIDTH-1:0] next_port;
  logic [spm_split_pkg::PORT_SEL_WIDTH-1:0] cur_port;
  logic [spm_split_pkg::PORT_SEL_WIDTH-1:0] owner_q;
  logic                                     owner_valid_q;
  logic                                     lock;
  logic                                     release_owner;

  // Lowest index wins, so scan downwards and keep the last hit
  always_comb begin
    next_port = '0;
    for (int i = spm_split_pkg::NUM_PORTS - 1; i >= 0; i--) begin
      if (req_i[i].data_req) next_port = i[spm_split_pkg::PORT_SEL_WIDTH-1:0];
    end
  end

  assign cur_port  = owner_valid_q ? owner_q : next_port;
  assign ext_req_o = req_i[cur_port];

  always_comb begin
    for (int i = 0; i < spm_split_pkg::NUM_PORTS; i++) begin
      rsp_o[i] = ext_rsp_i;
      if (cur_port != i) begin
        rsp_o[i].data_gnt    = 1'b0;
        rsp_o[i].data_rvalid = 1'b0;
      end
    end
  end

  // A granted read holds the port until its data is back
  assign lock          = !owner_valid_q && ext_req_o.data_req && ext_rsp_i.data_gnt &&
                         !ext_req_o.data_we;
  assign release_owner = owner_valid_q && ext_rsp_i.data_rvalid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_valid_q <= 1'b0;
      owner_q       <= '0;
    end else if (lock) begin
      owner_valid_q <= 1'b1;
      owner_q       <= next_port;
    end else if (release_owner) begin
      owner_valid_q <= 1'b0;
    end
  end

endmodule

// File: design/port_router.sv
`timescale 1ns/1ns

module port_router (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   stall_i,
  input  spm_split_pkg::mem_req_t req_i,
  output spm_split_pkg::mem_rsp_t rsp_o,
  output spm_split_pkg::mem_req_t dspm_req_o,
  output spm_split_pkg::mem_req_t ispm_req_o,
  output spm_split_pkg::mem_req_t cache_req_o,
  input  spm_split_pkg::mem_rsp_t dspm_rsp_i,
  input  spm_split_pkg::mem_rsp_t ispm_rsp_i,
  input  spm_split_pkg::mem_rsp_t cache_rsp_i
);

  spm_split_pkg::route_state_t state_d, state_q;
  spm_split_pkg::req_dest_t    dest_d, dest_q;
  spm_split_pkg::req_dest_t    new_dest;
  spm_split_pkg::req_dest_t    sel_dest;
  spm_split_pkg::mem_rsp_t     dest_rsp;
  logic                        fwd;

  assign new_dest = spm_split_pkg::decode_dest(req_i.addr);

  // --------------------------------------------------
  // Request steering
  // --------------------------------------------------
  always_comb begin
    // Idle decodes live, a pending read listens to the recorded target
    sel_dest = (state_q == spm_split_pkg::ROUTE_IDLE) ? new_dest : dest_q;
    fwd      = (state_q == spm_split_pkg::ROUTE_IDLE) && req_i.data_req && !stall_i;

    // All targets see the payload, only one may see the strobe
    dspm_req_o           = req_i;
    dspm_req_o.data_req  = 1'b0;
    ispm_req_o           = req_i;
    ispm_req_o.data_req  = 1'b0;
    cache_req_o          = req_i;
    cache_req_o.data_req = 1'b0;

    unique case (sel_dest)
      spm_split_pkg::DEST_DSPM: begin
        dspm_req_o.data_req = fwd;
        dest_rsp            = dspm_rsp_i;
      end
      spm_split_pkg::DEST_ISPM: begin
        ispm_req_o.data_req = fwd;
        dest_rsp            = ispm_rsp_i;
      end
      default: begin
        cache_req_o.data_req = fwd;
        dest_rsp             = cache_rsp_i;
      end
    endcase
  end

  // Grants only for a forwarded request, rvalid only while a read is pending
  assign rsp_o.data_gnt    = fwd && dest_rsp.data_gnt;
  assign rsp_o.data_rvalid = (state_q == spm_split_pkg::ROUTE_WAIT_RVALID) &&
                             dest_rsp.data_rvalid;
  assign rsp_o.rdata       = dest_rsp.rdata;

  // --------------------------------------------------
  // Read tracking FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    dest_d  = dest_q;
    unique case (state_q)
      spm_split_pkg::ROUTE_IDLE: begin
        if (rsp_o.data_gnt && !req_i.data_we) begin
          state_d = spm_split_pkg::ROUTE_WAIT_RVALID;
          dest_d  = new_dest;
        end
      end
      spm_split_pkg::ROUTE_WAIT_RVALID: begin
        if (dest_rsp.data_rvalid) state_d = spm_split_pkg::ROUTE_IDLE;
      end
      default: state_d = spm_split_pkg::ROUTE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= spm_split_pkg::ROUTE_IDLE;
      dest_q  <= spm_split_pkg::DEST_CACHE;
    end else begin
      state_q <= state_d;
      dest_q  <= dest_d;
    end
  end

endmodule

// File: design/way_sram.sv
`timescale 1ns/1ns

module way_sram (
  input  logic                                   clk_i,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [spm_split_pkg::WAY_IDX_WIDTH-1:0] addr_i,
  input  logic [spm_split_pkg::DATA_WIDTH-1:0]    wdata_i,
  input  logic [spm_split_pkg::BE_WIDTH-1:0]      be_i,
  output logic [spm_split_pkg::DATA_WIDTH-1:0]    rdata_o
);

  logic [spm_split_pkg::DATA_WIDTH-1:0] mem_q [spm_split_pkg::WAY_WORDS];

  // Byte-masked write, registered read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < spm_split_pkg::BE_WIDTH; b++) begin
          if (be_i[b]) mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// File: design/spm_split_pkg.sv
package spm_split_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned NUM_PORTS      = 2;
  localparam int unsigned PORT_SEL_WIDTH = $clog2(NUM_PORTS);
  localparam int unsigned NUM_WAYS       = 4;
  localparam int unsigned ADDR_WIDTH     = 16;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned BE_WIDTH       = 4;
  localparam int unsigned BYTE_OFF_WIDTH = $clog2(BE_WIDTH);
  localparam int unsigned WAY_WORDS      = 256;
  localparam int unsigned WAY_IDX_WIDTH  = 8;
  localparam int unsigned WAY_SEL_WIDTH  = 2;

  // Anything outside both SPM ranges goes to the cache
  localparam int unsigned DSPM_BASE   = 32'h8000;
  localparam int unsigned DSPM_LENGTH = 32'h1000;
  localparam int unsigned ISPM_BASE   = 32'hA000;
  localparam int unsigned ISPM_LENGTH = 32'h1000;

  typedef enum logic [1:0] {
    DEST_CACHE,
    DEST_DSPM,
    DEST_ISPM
  } req_dest_t;

  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_WAIT_RVALID
  } route_state_t;

  typedef struct packed {
    logic                  data_req;
    logic                  data_we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic                  data_gnt;
    logic                  data_rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

  function automatic req_dest_t decode_dest(input logic [ADDR_WIDTH-1:0] addr);
    if (addr >= DSPM_BASE && addr < DSPM_BASE + DSPM_LENGTH) return DEST_DSPM;
    if (addr >= ISPM_BASE && addr < ISPM_BASE + ISPM_LENGTH) return DEST_ISPM;
    return DEST_CACHE;
  endfunction

endpackage
